//--- axil_spi_regs.sv
//////////////////////////////
// AXI4-Lite register front end for the SPI master
// Write strobes ignored, only wdata[7:0] is used
// One outstanding write and one outstanding read
// Unmapped or wrong-direction access gives SLVERR
//////////////////////////////
`timescale 1ns/10ps

module axil_spi_regs
  import spi_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic        i_Clk,
  input  logic        i_Rst_L,
  // Write address and data channels
  input  logic        i_awvalid,
  output logic        o_awready,
  input  logic [3:0]  i_awaddr,
  input  logic        i_wvalid,
  output logic        o_wready,
  input  logic [31:0] i_wdata,
  // Write response channel
  output logic        o_bvalid,
  input  logic        i_bready,
  output logic [1:0]  o_bresp,
  // Read address channel
  input  logic        i_arvalid,
  output logic        o_arready,
  input  logic [3:0]  i_araddr,
  // Read data channel
  output logic        o_rvalid,
  input  logic        i_rready,
  output logic [31:0] o_rdata,
  output logic [1:0]  o_rresp,
  // Engine status
  input  logic        i_busy,
  input  logic        i_rx_drop,   // Byte lost on full rx FIFO
  byte_fifo_if.push   tx_push,
  byte_fifo_if.pop    rx_pop
);

  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

  axil_wr_state_e   wr_state;
  axil_rd_state_e   rd_state;
  spi_reg_e         wr_addr;
  spi_reg_e         rd_addr;
  logic             wr_accept;
  logic             rd_accept;
  logic             stat_rd;
  logic             rx_ovr;        // Sticky overflow
  logic [LVL_W-1:0] tx_lvl;
  logic [LVL_W-1:0] rx_lvl;
  logic [31:0]      status_word;

  assign wr_addr = spi_reg_e'(i_awaddr);
  assign rd_addr = spi_reg_e'(i_araddr);
  assign tx_lvl  = tx_push.level;
  assign rx_lvl  = rx_pop.level;

  //////////////////////////////
  // Write channel
  //////////////////////////////
  assign wr_accept = (wr_state == WR_IDLE) && i_awvalid && i_wvalid;
  assign o_awready = wr_accept;     // Address and data taken together
  assign o_wready  = wr_accept;
  assign o_bvalid  = (wr_state == WR_RESP);

  // Push only a TXDATA write that finds room
  assign tx_push.valid = wr_accept && (wr_addr == REG_TXDATA) && tx_push.ready;
  assign tx_push.data  = i_wdata[7:0];

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      wr_state <= WR_IDLE;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
        begin
          if (wr_accept)
            wr_state <= WR_RESP;
        end
        WR_RESP:
        begin
          if (i_bready)
            wr_state <= WR_IDLE;
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (wr_accept)
      o_bresp <= tx_push.valid ? RESP_OKAY : RESP_SLVERR;  // Full or bad addr
  end

  //////////////////////////////
  // Read channel
  //////////////////////////////
  assign o_arready    = (rd_state == RD_IDLE);
  assign rd_accept    = o_arready && i_arvalid;
  assign o_rvalid     = (rd_state == RD_DATA);
  assign rx_pop.ready = rd_accept && (rd_addr == REG_RXDATA);  // FIFO ignores pop on empty
  assign stat_rd      = rd_accept && (rd_addr == REG_STATUS);

  // Status word with levels zero-extended into their byte lanes
  always_comb
  begin
    status_word                = '0;
    status_word[STAT_TX_FULL]  = !tx_push.ready;
    status_word[STAT_TX_EMPTY] = (tx_lvl == '0);
    status_word[STAT_RX_EMPTY] = !rx_pop.valid;
    status_word[STAT_RX_OVR]   = rx_ovr;
    status_word[STAT_BUSY]     = i_busy;
    status_word[15:8]          = 8'(tx_lvl);
    status_word[23:16]         = 8'(rx_lvl);
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      rd_state <= RD_IDLE;
      rx_ovr   <= 1'b0;
    end
    else
    begin
      // A drop in the same cycle as a STATUS read stays visible
      if (i_rx_drop)
        rx_ovr <= 1'b1;
      else if (stat_rd)
        rx_ovr <= 1'b0;

      case (rd_state)
        RD_IDLE:
        begin
          if (rd_accept)
            rd_state <= RD_DATA;
        end
        RD_DATA:
        begin
          if (i_rready)
            rd_state <= RD_IDLE;
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // Read data captured on the accept edge
  always_ff @(posedge i_Clk)
  begin
    if (rd_accept)
    begin
      case (rd_addr)
        REG_RXDATA:
        begin
          if (rx_pop.valid)
          begin
            o_rdata <= {24'h000000, rx_pop.data};
            o_rresp <= RESP_OKAY;
          end
          else
          begin
            o_rdata <= '0;            // Empty rx FIFO
            o_rresp <= RESP_SLVERR;
          end
        end
        REG_STATUS:
        begin
          o_rdata <= status_word;
          o_rresp <= RESP_OKAY;
        end
        default:
        begin
          o_rdata <= '0;              // TXDATA is write only, rest unmapped
          o_rresp <= RESP_SLVERR;
        end
      endcase
    end
  end

endmodule : axil_spi_regs

//--- byte_fifo.sv
//////////////////////////////
// Show-ahead byte FIFO
// FIFO_DEPTH must be a power of two, 2 or more
// Push on full and pop on empty are ignored
//////////////////////////////
`timescale 1ns/10ps

module byte_fifo #(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic          i_Clk,
  input  logic          i_Rst_L,
  byte_fifo_if.fifo_in  wr,
  byte_fifo_if.fifo_out rd
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [7:0]  mem [FIFO_DEPTH];
  logic [AW:0] wr_ptr;          // Extra MSB tells full from empty
  logic [AW:0] rd_ptr;
  logic [AW:0] level;
  logic        full;
  logic        do_push;
  logic        do_pop;

  assign level   = wr_ptr - rd_ptr;
  assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign do_push = wr.valid && wr.ready;
  assign do_pop  = rd.valid && rd.ready;

  // Handshake and level out to both sides
  assign wr.ready = !full;
  assign wr.level = level;
  assign rd.valid = (level != '0);
  assign rd.level = level;
  assign rd.data  = mem[rd_ptr[AW-1:0]];   // Head word, no read latency

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge i_Clk)
  begin
    if (do_push)
      mem[wr_ptr[AW-1:0]] <= wr.data;
  end

endmodule : byte_fifo

//--- byte_fifo_if.sv
//////////////////////////////
// One byte stream plus FIFO fill level
// A byte moves when valid and ready are both high
//////////////////////////////
`timescale 1ns/10ps

interface byte_fifo_if #(
  parameter int FIFO_DEPTH = 8
);
  localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;  // Holds 0 to FIFO_DEPTH

  logic             valid;
  logic             ready;
  logic [7:0]       data;
  logic [LVL_W-1:0] level;  // Always driven by the FIFO

  // Producer side of a stream
  modport push (output valid, output data, input ready, input level);

  // Consumer side of a stream
  modport pop (input valid, input data, output ready, input level);

  // FIFO write side
  modport fifo_in (input valid, input data, output ready, output level);

  // FIFO read side
  modport fifo_out (output valid, output data, input ready, output level);

endinterface : byte_fifo_if

//--- compile.f
spi_pkg.sv
byte_fifo_if.sv
byte_fifo.sv
axil_spi_regs.sv
spi_master.sv
spi_ctrl_top.sv
tb_clock_gen.sv
spi_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module spi_ctrl_tb -Mdir obj_dir -o spi_ctrl_sim -f compile.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/spi_ctrl_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- spi_ctrl_tb.sv
//////////////////////////////
// Testbench for the AXI4-Lite SPI master
// MOSI looped back to MISO, SPI mode 0, 2 clocks per half bit
// Inputs change 2 ns after the rising edge, outputs read on the falling edge
// Stops at the first failing check
//////////////////////////////
`timescale 1ns/10ps

module spi_ctrl_tb;

  localparam int CLKS_PER_HALF_BIT = 2;
  localparam int FIFO_DEPTH        = 8;
  localparam int TIMEOUT_CYCLES    = 20000;  // About 30 transfers of 36 cycles plus polling

  // Register map
  localparam logic [3:0] ADDR_TXDATA   = 4'h0;
  localparam logic [3:0] ADDR_RXDATA   = 4'h4;
  localparam logic [3:0] ADDR_STATUS   = 4'h8;
  localparam logic [3:0] ADDR_UNMAPPED = 4'hC;

  // Status word layout
  localparam int BIT_TX_FULL  = 0;
  localparam int BIT_TX_EMPTY = 1;
  localparam int BIT_RX_EMPTY = 2;
  localparam int BIT_RX_OVR   = 3;
  localparam int BIT_BUSY     = 4;

  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic        i_Clk;
  logic        i_Rst_L;
  logic        i_awvalid;
  logic        o_awready;
  logic [3:0]  i_awaddr;
  logic        i_wvalid;
  logic        o_wready;
  logic [31:0] i_wdata;
  logic        o_bvalid;
  logic        i_bready;
  logic [1:0]  o_bresp;
  logic        i_arvalid;
  logic        o_arready;
  logic [3:0]  i_araddr;
  logic        o_rvalid;
  logic        i_rready;
  logic [31:0] o_rdata;
  logic [1:0]  o_rresp;
  logic        o_SPI_Clk;
  logic        spi_loop;      // MOSI fed straight back as MISO

  integer      seed;
  logic [7:0]  exp_q[$];      // Bytes sent and not yet read back
  int          cycle_cnt = 0;
  logic        sclk_prev;
  int          run_len;       // Falling edges spent at the current SCLK level
  int          rise_cnt;

  tb_clock_gen #(.PERIOD_NS(40)) u_clk (.o_Clk(i_Clk));

  spi_ctrl_top #(
    .SPI_MODE          (0),
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT),
    .FIFO_DEPTH        (FIFO_DEPTH)
  ) uut (
    .i_Clk (i_Clk), .i_Rst_L (i_Rst_L),
    .i_awvalid (i_awvalid), .o_awready (o_awready), .i_awaddr (i_awaddr),
    .i_wvalid (i_wvalid), .o_wready (o_wready), .i_wdata (i_wdata),
    .o_bvalid (o_bvalid), .i_bready (i_bready), .o_bresp (o_bresp),
    .i_arvalid (i_arvalid), .o_arready (o_arready), .i_araddr (i_araddr),
    .o_rvalid (o_rvalid), .i_rready (i_rready), .o_rdata (o_rdata), .o_rresp (o_rresp),
    .o_SPI_Clk (o_SPI_Clk), .o_SPI_MOSI (spi_loop), .i_SPI_MISO (spi_loop)
  );

  //////////////////////////////
  // Checking helpers
  //////////////////////////////
  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_on_error($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  // Expected status word of an idle engine
  function automatic logic [31:0] exp_status(input bit ovr, input int tx_lvl, input int rx_lvl);
    logic [31:0] w;
    w               = '0;
    w[BIT_TX_FULL]  = (tx_lvl == FIFO_DEPTH);
    w[BIT_TX_EMPTY] = (tx_lvl == 0);
    w[BIT_RX_EMPTY] = (rx_lvl == 0);
    w[BIT_RX_OVR]   = ovr;
    w[BIT_BUSY]     = 1'b0;
    w[15:8]         = 8'(tx_lvl);
    w[23:16]        = 8'(rx_lvl);
    return w;
  endfunction

  //////////////////////////////
  // AXI4-Lite driver tasks
  //////////////////////////////
  // Entered and left 2 ns after a rising edge
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input int hold, output logic [1:0] resp);
    bit         accepted;
    logic [1:0] held_resp;
    accepted  = 1'b0;
    i_awaddr  = addr;
    i_wdata   = data;
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    while (!accepted)
    begin
      @(negedge i_Clk);
      accepted = o_awready;     // Taken on the coming edge
      @(posedge i_Clk);
      #2;
    end
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    do
    begin
      @(negedge i_Clk);
    end
    while (!o_bvalid);
    held_resp = o_bresp;
    repeat (hold)                // Response must wait while bready is low
    begin
      @(negedge i_Clk);
      assert (o_bvalid && (o_bresp === held_resp))
        else stop_on_error($sformatf("[FAIL] %0t: write response dropped or changed", $time));
    end
    @(posedge i_Clk);
    #2;
    i_bready = 1'b1;
    @(posedge i_Clk);
    #2;
    i_bready = 1'b0;
    resp     = held_resp;
  endtask

  task automatic axi_read(input logic [3:0] addr, input int hold,
                          output logic [31:0] data, output logic [1:0] resp);
    bit accepted;
    accepted  = 1'b0;
    i_araddr  = addr;
    i_arvalid = 1'b1;
    while (!accepted)
    begin
      @(negedge i_Clk);
      accepted = o_arready;
      @(posedge i_Clk);
      #2;
    end
    i_arvalid = 1'b0;
    do
    begin
      @(negedge i_Clk);
    end
    while (!o_rvalid);
    data = o_rdata;
    resp = o_rresp;
    repeat (hold)
    begin
      @(negedge i_Clk);
      assert (o_rvalid && (o_rdata === data) && (o_rresp === resp))
        else stop_on_error($sformatf("[FAIL] %0t: read response dropped or changed", $time));
    end
    @(posedge i_Clk);
    #2;
    i_rready = 1'b1;
    @(posedge i_Clk);
    #2;
    i_rready = 1'b0;
  endtask

  // Repeat STATUS reads until the engine is idle with rx_lvl bytes held
  task automatic poll_status(input int rx_lvl, output logic [31:0] word);
    logic [1:0] resp;
    do
    begin
      axi_read(ADDR_STATUS, 0, word, resp);
      check_value("STATUS response", resp, OKAY);
    end
    while (word[BIT_BUSY] || !word[BIT_TX_EMPTY] || (word[23:16] != 8'(rx_lvl)));
  endtask

  task automatic send_random_byte(input int hold);
    logic [31:0] data;
    logic [1:0]  resp;
    data = $random(seed);       // Upper bits ignored by the DUT
    axi_write(ADDR_TXDATA, data, hold, resp);
    check_value("TXDATA write response", resp, OKAY);
    exp_q.push_back(data[7:0]);
  endtask

  task automatic read_expected_byte(input int hold);
    logic [31:0] data;
    logic [1:0]  resp;
    axi_read(ADDR_RXDATA, hold, data, resp);
    check_value("RXDATA response", resp, OKAY);
    check_value("RXDATA byte", data, {24'h000000, exp_q.pop_front()});
  endtask

  //////////////////////////////
  // Protocol assertions
  //////////////////////////////
  assert property (@(posedge i_Clk) o_awready == o_wready)
    else stop_on_error($sformatf("[FAIL] %0t: awready and wready differ", $time));

  assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
                   (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bresp)))
    else stop_on_error($sformatf("[FAIL] %0t: bvalid or bresp changed before bready", $time));

  assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
                   (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rdata) && $stable(o_rresp)))
    else stop_on_error($sformatf("[FAIL] %0t: rvalid or rdata changed before rready", $time));

  // No response without a request
  assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
                   $rose(o_bvalid) |-> $past(i_awvalid && o_awready))
    else stop_on_error($sformatf("[FAIL] %0t: bvalid without a write", $time));

  assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
                   $rose(o_rvalid) |-> $past(i_arvalid && o_arready))
    else stop_on_error($sformatf("[FAIL] %0t: rvalid without a read", $time));

  // SCLK half periods except the first low gap of each byte
  always @(negedge i_Clk)
  begin
    if (!i_Rst_L)
    begin
      sclk_prev = 1'b0;
      run_len   = 0;
      rise_cnt  = 0;
    end
    else if (o_SPI_Clk == sclk_prev)
    begin
      run_len = run_len + 1;
    end
    else
    begin
      if (!o_SPI_Clk || ((rise_cnt % 8) != 0))
        assert (run_len == CLKS_PER_HALF_BIT)
          else stop_on_error($sformatf("[FAIL] %0t: SCLK half period %0d cycles, expected %0d",
                                       $time, run_len, CLKS_PER_HALF_BIT));
      if (o_SPI_Clk)
        rise_cnt = rise_cnt + 1;
      run_len   = 1;
      sclk_prev = o_SPI_Clk;
    end
  end

  // Run limit
  always @(posedge i_Clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_on_error($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial
  begin
    logic [31:0] word;
    logic [31:0] data;
    logic [1:0]  resp;
    seed      = 32'h5ebe14e3;
    i_Rst_L   = 1'b0;
    i_awvalid = 1'b0;
    i_awaddr  = '0;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_bready  = 1'b0;
    i_arvalid = 1'b0;
    i_araddr  = '0;
    i_rready  = 1'b0;
    repeat (16) @(posedge i_Clk);
    #2;
    i_Rst_L = 1'b1;

    // Quiet outputs after reset
    repeat (4)
    begin
      @(negedge i_Clk);
      assert (!o_bvalid && !o_rvalid && !o_SPI_Clk && !spi_loop)
        else stop_on_error($sformatf("[FAIL] %0t: outputs active after reset", $time));
    end
    @(posedge i_Clk);
    #2;
    axi_read(ADDR_STATUS, 0, word, resp);
    check_value("STATUS response after reset", resp, OKAY);
    check_value("STATUS after reset", word, exp_status(1'b0, 0, 0));

    // Single byte loopback
    send_random_byte(0);
    poll_status(1, word);
    read_expected_byte(0);

    // Burst keeps order
    repeat (8) send_random_byte(0);
    poll_status(8, word);
    repeat (8) read_expected_byte(0);

    // Error responses
    axi_read(ADDR_RXDATA, 0, data, resp);
    check_value("empty RXDATA response", resp, SLVERR);
    check_value("empty RXDATA data", data, 32'h0);
    axi_write(ADDR_STATUS, 32'h0000_005A, 0, resp);
    check_value("STATUS write response", resp, SLVERR);
    axi_read(ADDR_UNMAPPED, 0, data, resp);
    check_value("unmapped read response", resp, SLVERR);

    // Ninth byte lands on a full rx FIFO
    repeat (FIFO_DEPTH + 1) send_random_byte(0);
    poll_status(FIFO_DEPTH, word);
    check_value("STATUS after overflow", word, exp_status(1'b1, 0, FIFO_DEPTH));
    axi_read(ADDR_STATUS, 0, word, resp);
    check_value("second STATUS after overflow", word, exp_status(1'b0, 0, FIFO_DEPTH));
    repeat (FIFO_DEPTH) read_expected_byte(0);
    axi_read(ADDR_STATUS, 0, word, resp);
    check_value("STATUS after draining", word, exp_status(1'b0, 0, 0));
    exp_q.delete();             // Ninth byte never reached the rx FIFO

    // Responses held while bready and rready stay low
    send_random_byte(5);
    poll_status(1, word);
    read_expected_byte(5);
    axi_read(ADDR_STATUS, 5, word, resp);
    check_value("held STATUS", word, exp_status(1'b0, 0, 0));

    $display("Result: PASSED");
    $finish;
  end

endmodule : spi_ctrl_tb

//--- spi_ctrl_top.sv
//////////////////////////////
// AXI4-Lite SPI master top level
// Address is 4 bits, data 32 bits
// i_Clk at least 4x the SPI clock, no CDC
//////////////////////////////
`timescale 1ns/10ps

module spi_ctrl_top #(
  parameter int SPI_MODE          = 0,
  parameter int CLKS_PER_HALF_BIT = 2,
  parameter int FIFO_DEPTH        = 8
)
(
  input  logic        i_Clk,
  input  logic        i_Rst_L,
  // AXI4-Lite slave
  input  logic        i_awvalid,
  output logic        o_awready,
  input  logic [3:0]  i_awaddr,
  input  logic        i_wvalid,
  output logic        o_wready,
  input  logic [31:0] i_wdata,
  output logic        o_bvalid,
  input  logic        i_bready,
  output logic [1:0]  o_bresp,
  input  logic        i_arvalid,
  output logic        o_arready,
  input  logic [3:0]  i_araddr,
  output logic        o_rvalid,
  input  logic        i_rready,
  output logic [31:0] o_rdata,
  output logic [1:0]  o_rresp,
  // SPI pins
  output logic        o_SPI_Clk,
  output logic        o_SPI_MOSI,
  input  logic        i_SPI_MISO
);

  logic busy;
  logic rx_drop;

  // Streams on each side of the two FIFOs
  byte_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) tx_push ();
  byte_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) tx_pop ();
  byte_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) rx_push ();
  byte_fifo_if #(.FIFO_DEPTH(FIFO_DEPTH)) rx_pop ();

  axil_spi_regs #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_regs (
    .i_Clk     (i_Clk),
    .i_Rst_L   (i_Rst_L),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .i_busy    (busy),
    .i_rx_drop (rx_drop),
    .tx_push   (tx_push.push),
    .rx_pop    (rx_pop.pop)
  );

  byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .i_Clk   (i_Clk),
    .i_Rst_L (i_Rst_L),
    .wr      (tx_push.fifo_in),
    .rd      (tx_pop.fifo_out)
  );

  byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .i_Clk   (i_Clk),
    .i_Rst_L (i_Rst_L),
    .wr      (rx_push.fifo_in),
    .rd      (rx_pop.fifo_out)
  );

  spi_master #(
    .SPI_MODE          (SPI_MODE),
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
  ) u_engine (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .o_SPI_Clk  (o_SPI_Clk),
    .o_SPI_MOSI (o_SPI_MOSI),
    .i_SPI_MISO (i_SPI_MISO),
    .o_busy     (busy),
    .o_rx_drop  (rx_drop),
    .tx_pop     (tx_pop.pop),
    .rx_push    (rx_push.push)
  );

endmodule : spi_ctrl_top

//--- spi_master.sv
//////////////////////////////
// SPI master engine, one byte each way per transfer, MSB first
// SPI_MODE 0 to 3, CLKS_PER_HALF_BIT must be 2 or more
// No chip select, a higher level owns it
// Never stalls, a full rx FIFO drops the byte
//////////////////////////////
`timescale 1ns/10ps

module spi_master
  import spi_pkg::*;
#(
  parameter int SPI_MODE          = 0,
  parameter int CLKS_PER_HALF_BIT = 2
)
(
  input  logic        i_Clk,
  input  logic        i_Rst_L,
  // SPI pins
  output logic        o_SPI_Clk,
  output logic        o_SPI_MOSI,
  input  logic        i_SPI_MISO,
  // Status
  output logic        o_busy,
  output logic        o_rx_drop,   // One-cycle pulse on lost byte
  byte_fifo_if.pop    tx_pop,
  byte_fifo_if.push   rx_push
);

  localparam bit CPOL  = (SPI_MODE == 2) || (SPI_MODE == 3);  // Idle level of SCLK
  localparam bit CPHA  = (SPI_MODE == 1) || (SPI_MODE == 3);  // 1: drive on leading edge
  localparam int CNT_W = $clog2(2 * CLKS_PER_HALF_BIT);

  spi_state_e       state;
  logic [CNT_W-1:0] clk_cnt;      // Position inside one bit period
  logic [4:0]       edges;        // SCLK edges left, 16 per byte
  logic             sclk;         // Internal SCLK, one cycle ahead of pin
  logic             lead;         // Strobe, leading edge just made
  logic             trail;        // Strobe, trailing edge just made
  logic [2:0]       tx_bit;
  logic [2:0]       rx_bit;
  logic [7:0]       tx_byte;
  logic [7:0]       rx_byte;
  logic             tx_take;
  logic             shift_out;
  logic             sample_in;

  // Take the next byte from IDLE, or straight from DONE for back-to-back
  assign tx_pop.ready = (state == SPI_IDLE) || (state == SPI_DONE);
  assign tx_take      = tx_pop.valid && tx_pop.ready;

  assign shift_out = CPHA ? lead : trail;   // Edge that moves MOSI
  assign sample_in = CPHA ? trail : lead;   // Other edge samples MISO

  assign o_busy        = (state != SPI_IDLE);
  assign rx_push.valid = (state == SPI_DONE);
  assign rx_push.data  = rx_byte;
  assign o_rx_drop     = (state == SPI_DONE) && !rx_push.ready;

  //////////////////////////////
  // FSM and SCLK generation
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      state   <= SPI_IDLE;
      clk_cnt <= '0;
      edges   <= '0;
      sclk    <= CPOL;
      lead    <= 1'b0;
      trail   <= 1'b0;
    end
    else
    begin
      lead  <= 1'b0;   // Strobes last one cycle
      trail <= 1'b0;
      case (state)
        SPI_IDLE:
        begin
          if (tx_take)
            state <= SPI_LOAD;
        end
        SPI_LOAD:
        begin
          edges   <= 5'd16;
          clk_cnt <= '0;
          sclk    <= CPOL;
          state   <= SPI_SHIFT;
        end
        SPI_SHIFT:
        begin
          if (edges != '0)
          begin
            if (clk_cnt == CNT_W'(2 * CLKS_PER_HALF_BIT - 1))
            begin
              edges   <= edges - 1'b1;
              trail   <= 1'b1;
              clk_cnt <= '0;
              sclk    <= ~sclk;
            end
            else if (clk_cnt == CNT_W'(CLKS_PER_HALF_BIT - 1))
            begin
              edges   <= edges - 1'b1;
              lead    <= 1'b1;
              clk_cnt <= clk_cnt + 1'b1;
              sclk    <= ~sclk;
            end
            else
            begin
              clk_cnt <= clk_cnt + 1'b1;
            end
          end
          else if (trail)
          begin
            state <= SPI_DONE;   // Last trailing strobe handled this cycle
          end
        end
        SPI_DONE:
        begin
          state <= tx_take ? SPI_LOAD : SPI_IDLE;
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // MOSI drive and bit counters
  //////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_SPI_MOSI <= 1'b0;
      tx_bit     <= 3'd7;
      rx_bit     <= 3'd7;
    end
    else if (state == SPI_LOAD)
    begin
      rx_bit <= 3'd7;
      if (!CPHA)
      begin
        o_SPI_MOSI <= tx_byte[7];   // MSB must be out before first edge
        tx_bit     <= 3'd6;
      end
      else
      begin
        tx_bit <= 3'd7;
      end
    end
    else
    begin
      if (shift_out)
      begin
        o_SPI_MOSI <= tx_byte[tx_bit];
        tx_bit     <= tx_bit - 1'b1;
      end
      if (sample_in)
        rx_bit <= rx_bit - 1'b1;
    end
  end

  // Byte registers
  always_ff @(posedge i_Clk)
  begin
    if (tx_take)
      tx_byte <= tx_pop.data;
    if (sample_in)
      rx_byte[rx_bit] <= i_SPI_MISO;
  end

  // SCLK pin delayed one cycle to line up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_SPI_Clk <= CPOL;
    else
      o_SPI_Clk <= sclk;
  end

endmodule : spi_master

//--- spi_pkg.sv
//////////////////////////////
// Shared types for the AXI4-Lite SPI master
// Register decode uses only the low 4 address bits
// Status levels assume FIFO_DEPTH of 128 or less
//////////////////////////////
package spi_pkg;

  //////////////////////////////
  // Register map
  //////////////////////////////
  typedef enum logic [3:0] {
    REG_TXDATA = 4'h0,  // Write only, low byte goes to tx FIFO
    REG_RXDATA = 4'h4,  // Read only, pops rx FIFO
    REG_STATUS = 4'h8   // Read only, clears sticky overflow
  } spi_reg_e;

  //////////////////////////////
  // Channel and engine states
  //////////////////////////////
  typedef enum logic {
    WR_IDLE,
    WR_RESP             // bvalid held until bready
  } axil_wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_DATA             // rvalid held until rready
  } axil_rd_state_e;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_LOAD,           // Set up counters and first MOSI bit
    SPI_SHIFT,          // 16 SCLK edges
    SPI_DONE            // Push received byte
  } spi_state_e;

  // Status word bit positions
  localparam int STAT_TX_FULL  = 0;
  localparam int STAT_TX_EMPTY = 1;
  localparam int STAT_RX_EMPTY = 2;
  localparam int STAT_RX_OVR   = 3;   // Sticky
  localparam int STAT_BUSY     = 4;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage : spi_pkg

//--- tb_clock_gen.sv
//////////////////////////////
// Free-running testbench clock
// Starts low, first rising edge after half a period
//////////////////////////////
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
)
(
  output logic o_Clk
);

  initial
  begin
    o_Clk = 1'b0;
    forever
    begin
      #(PERIOD_NS / 2) o_Clk = ~o_Clk;  // Half period high, half low
    end
  end

endmodule : tb_clock_gen
